// File: common/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

	////////////////////////////////////////////////////////////
	// Bus types shared by the upstream and memory sides
	////////////////////////////////////////////////////////////

	localparam int word_bits = 16;    // Byte address width.
	localparam int line_bits = 256;   // One full cache line.

	typedef logic [word_bits-1:0] mem_word_t;
	typedef logic [line_bits-1:0] mem_line_t;

	// Request fields are held as levels until the matching done pulse.
	typedef struct packed
	{
		logic      read;      // Line read.
		logic      write;     // Full line write.
		mem_word_t address;   // Byte address, offset ignored.
		mem_line_t wdata;     // Write payload.
	} mem_req_t;

endpackage : mem_bus_pkg

`default_nettype wire

// File: common/victim_pkg.sv
`default_nettype none

package victim_pkg;

	import mem_bus_pkg::*;

	////////////////////////////////////////////////////////////
	// Victim buffer tags and controller states
	////////////////////////////////////////////////////////////

	localparam int line_offset_bits = 5;   // 32 bytes per line.
	localparam int tag_bits = $bits(mem_word_t) - line_offset_bits;

	typedef logic [tag_bits-1:0] vc_tag_t;

	typedef enum logic [1:0]
	{
		idle,        // Waiting for a request.
		writeback,   // Oldest entry going out to memory.
		fetch,       // Read miss forwarded to memory.
		done         // One-cycle completion.
	} vc_state_t;

	// Line tag of a byte address.
	function automatic vc_tag_t tag_of(input mem_word_t address);
		return address[$bits(mem_word_t)-1:line_offset_bits];
	endfunction

	// Line-aligned byte address of a tag.
	function automatic mem_word_t line_address(input vc_tag_t tag);
		return {tag, {line_offset_bits{1'b0}}};
	endfunction

endpackage : victim_pkg

`default_nettype wire

// File: files.f
common/mem_bus_pkg.sv
common/victim_pkg.sv
rtl/repl_counter.sv
victim_cache/victim_store.sv
victim_cache/victim_lookup.sv
victim_cache/victim_ctrl.sv
victim_cache/victim_cache.sv
tb/physical_memory.sv
tb/victim_cache_checker.sv
tb/victim_cache_properties.sv
tb/victim_cache_tb.sv

// File: rtl/repl_counter.sv
`timescale 1ns/1ps
`default_nettype none

module repl_counter
#(
	parameter int num_entries = 4,
	localparam int index_bits = $clog2(num_entries),
	localparam int count_bits = $clog2(num_entries + 1)
)
(
	input  logic                  buf_mem_resp,
	input  logic                  rst,
	input  logic                  advance,
	output logic [index_bits-1:0] ptr,
	output logic                  full
);

	logic [count_bits-1:0] count;

	// Pointer names the next free entry, then the oldest once full.
	always_ff @(posedge buf_mem_resp)
	begin
		if (rst)
		begin
			ptr   <= '0;
			count <= '0;
		end
		else if (advance)
		begin
			ptr <= (ptr == index_bits'(num_entries - 1)) ? '0 : ptr + 1'b1;
			if (!full)
				count <= count + 1'b1;   // Saturates at num_entries.
		end
	end

	assign full = (count == count_bits'(num_entries));

endmodule : repl_counter

`default_nettype wire

// File: tb/physical_memory.sv
`timescale 1ns/1ps
`default_nettype none

module physical_memory
	import mem_bus_pkg::*;
#(
	parameter int delay = 3
)
(
	input  logic      buf_mem_resp,
	input  logic      rst,
	input  mem_req_t  req,
	output logic      resp,
	output mem_line_t rdata
);

	mem_line_t lines [mem_word_t];   // Only written lines are kept.
	mem_req_t  held;
	logic      busy;
	int        wait_count;

	// Unwritten lines hold their line address in every 16-bit word.
	function automatic mem_line_t pattern_line(input mem_word_t line_addr);
		return {16{line_addr}};
	endfunction

	initial
	begin
		resp  = 1'b0;
		rdata = '0;
		busy  = 1'b0;
	end

	always @(posedge buf_mem_resp)
	begin
		mem_word_t key;
		resp <= 1'b0;
		if (rst)
		begin
			busy = 1'b0;
			lines.delete();   // Back to the fill pattern.
		end
		else if (!busy && !resp && (req.read || req.write))
		begin
			held       = req;
			busy       = 1'b1;
			wait_count = delay - 1;
		end
		else if (busy && wait_count > 0)
			wait_count = wait_count - 1;
		else if (busy)
		begin
			busy = 1'b0;
			resp <= 1'b1;
			key  = {held.address[15:5], 5'h00};
			if (held.write)
				lines[key] = held.wdata;
			else
				rdata <= lines.exists(key) ? lines[key] : pattern_line(key);
		end
	end

endmodule : physical_memory

`default_nettype wire

// File: tb/victim_cache_checker.sv
`timescale 1ns/1ps
`default_nettype none

module victim_cache_checker
	import mem_bus_pkg::*;
(
	input logic      buf_mem_resp,
	input logic      rst,
	input mem_req_t  buf_mem_req,
	input logic      buf_mem_done,
	input mem_line_t buf_mem_rdata,
	input mem_req_t  s_mem_req,
	input logic      s_mem_resp
);

	mem_line_t read_q [$];   // Expected lines of issued reads.
	mem_req_t  wb_q [$];     // Expected memory writes, in order.
	logic      strict_wb    = 1'b0;
	logic      fast_only    = 1'b0;
	int        wait_cycles  = 0;
	int        test_errors  = 0;
	int        error_count  = 0;
	int        test_num     = 0;
	int        tests_passed = 0;

	task automatic expect_read(input mem_line_t line);
		read_q.push_back(line);
	endtask

	task automatic expect_writeback(input mem_word_t address, input mem_line_t line);
		mem_req_t wb;
		wb         = '0;
		wb.write   = 1'b1;
		wb.address = {address[15:5], 5'h00};
		wb.wdata   = line;
		wb_q.push_back(wb);
	endtask

	task automatic begin_test(input logic strict, input logic fast);
		strict_wb   = strict;
		fast_only   = fast;
		test_errors = 0;
		wb_q.delete();
		read_q.delete();
	endtask

	task automatic record_error(input string msg);
		$display("Error at %0t: %s", $time, msg);
		test_errors++;
		error_count++;
	endtask

	task automatic end_test(input string name);
		test_num++;
		if (wb_q.size() != 0)
		begin
			$display("Test %0d: %0d expected memory writes never happened", test_num, wb_q.size());
			test_errors++;
			error_count++;
		end
		if (test_errors == 0)
		begin
			tests_passed++;
			$display("Test %0d passed: %s", test_num, name);
		end
		else
			$display("Test %0d failed: %s, %0d errors", test_num, name, test_errors);
	endtask

	task automatic report_counts();
		$display("Tests run %0d, passed %0d, failed %0d, errors %0d",
			test_num, tests_passed, test_num - tests_passed, error_count);
	endtask

	////////////////////////////////////////////////////////////
	// Port monitor
	////////////////////////////////////////////////////////////

	always @(posedge buf_mem_resp)
	begin
		mem_line_t want;
		mem_req_t  wb;
		if (rst)
			wait_cycles = 0;
		else
		begin
			if (s_mem_req.write && s_mem_resp && strict_wb)
			begin
				if (wb_q.size() == 0)
					record_error($sformatf("unexpected memory write to %h", s_mem_req.address));
				else
				begin
					wb = wb_q.pop_front();
					if (s_mem_req.address !== wb.address || s_mem_req.wdata !== wb.wdata)
						record_error($sformatf("memory write to %h, expected line %h",
							s_mem_req.address, wb.address));
				end
			end
			if (buf_mem_done)
			begin
				if (fast_only && wait_cycles != 1)
					record_error($sformatf("done took %0d cycles, expected 1", wait_cycles));
				if (buf_mem_req.read && read_q.size() == 0)
					record_error("read finished with no expected value");
				else if (buf_mem_req.read)
				begin
					want = read_q.pop_front();
					if (buf_mem_rdata !== want)
						record_error($sformatf("read of %h returned %h, expected %h",
							buf_mem_req.address, buf_mem_rdata, want));
				end
				wait_cycles = 0;
			end
			else if (buf_mem_req.read || buf_mem_req.write)
				wait_cycles++;   // Edges with the request pending.
		end
	end

endmodule : victim_cache_checker

`default_nettype wire

// File: tb/victim_cache_properties.sv
`timescale 1ns/1ps
`default_nettype none

module victim_cache_properties
	import mem_bus_pkg::*;
(
	input logic     buf_mem_resp,
	input logic     rst,
	input logic     buf_mem_done,
	input mem_req_t s_mem_req,
	input logic     s_mem_resp
);

	int failures = 0;   // Failed assertions so far.

	one_memory_op: assert property (@(posedge buf_mem_resp) disable iff (rst)
		!(s_mem_req.read && s_mem_req.write))
	else
	begin
		failures++;
		$error("memory read and write raised together");
	end

	done_single: assert property (@(posedge buf_mem_resp) disable iff (rst)
		buf_mem_done |=> !buf_mem_done)
	else
	begin
		failures++;
		$error("buf_mem_done held for two cycles");
	end

	// Request toward memory holds until the response.
	req_held: assert property (@(posedge buf_mem_resp) disable iff (rst)
		(s_mem_req.read || s_mem_req.write) && !s_mem_resp |=> $stable(s_mem_req))
	else
	begin
		failures++;
		$error("s_mem_req changed before s_mem_resp");
	end

endmodule : victim_cache_properties

bind victim_cache victim_cache_properties props_inst
(
	.buf_mem_resp(buf_mem_resp),
	.rst         (rst),
	.buf_mem_done(buf_mem_done),
	.s_mem_req   (s_mem_req),
	.s_mem_resp  (s_mem_resp)
);

`default_nettype wire

// File: tb/victim_cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module victim_cache_tb
	import mem_bus_pkg::*;
#(
	parameter int num_entries = 4
);

	localparam int timeout_cycles = 5000;   // About 230 ops of up to 12 cycles, with margin.

	logic      buf_mem_resp;
	logic      rst;
	mem_req_t  buf_mem_req;
	logic      buf_mem_done;
	mem_line_t buf_mem_rdata;
	mem_req_t  s_mem_req;
	logic      s_mem_resp;
	mem_line_t s_mem_rdata;
	mem_line_t written [mem_word_t];   // Reference contents by line address.
	int        cycles = 0;

	victim_cache #(.num_entries(num_entries)) victim_cache_inst
	(
		.buf_mem_resp (buf_mem_resp),
		.rst          (rst),
		.buf_mem_req  (buf_mem_req),
		.buf_mem_done (buf_mem_done),
		.buf_mem_rdata(buf_mem_rdata),
		.s_mem_req    (s_mem_req),
		.s_mem_resp   (s_mem_resp),
		.s_mem_rdata  (s_mem_rdata)
	);

	physical_memory #(.delay(3)) memory_inst
	(
		.buf_mem_resp(buf_mem_resp),
		.rst         (rst),
		.req         (s_mem_req),
		.resp        (s_mem_resp),
		.rdata       (s_mem_rdata)
	);

	victim_cache_checker checker_inst
	(
		.buf_mem_resp (buf_mem_resp),
		.rst          (rst),
		.buf_mem_req  (buf_mem_req),
		.buf_mem_done (buf_mem_done),
		.buf_mem_rdata(buf_mem_rdata),
		.s_mem_req    (s_mem_req),
		.s_mem_resp   (s_mem_resp)
	);

	initial
	begin
		buf_mem_resp = 1'b0;
		forever
			#20 buf_mem_resp = ~buf_mem_resp;
	end

	// Last line written to an address, else the memory fill pattern.
	function automatic mem_line_t expected_line(input mem_word_t address);
		mem_word_t key;
		key = {address[15:5], 5'h00};
		if (written.exists(key))
			return written[key];
		return {16{key}};
	endfunction

	function automatic mem_line_t random_line();
		mem_line_t line;
		for (int i = 0; i < 8; i++)
			line[i*32 +: 32] = $urandom();
		return line;
	endfunction

	task automatic apply_reset();
		@(posedge buf_mem_resp);
		rst         <= 1'b1;
		buf_mem_req <= '0;
		repeat (10) @(posedge buf_mem_resp);
		rst <= 1'b0;
		written.delete();   // Memory model clears on reset too.
	endtask

	task automatic run_op(input logic is_write, input mem_word_t address, input mem_line_t data);
		mem_req_t req;
		req = '{read: !is_write, write: is_write, address: address, wdata: data};
		@(posedge buf_mem_resp);
		if (is_write)
			written[{address[15:5], 5'h00}] = data;
		else
			checker_inst.expect_read(expected_line(address));
		buf_mem_req <= req;
		do
			@(posedge buf_mem_resp);
		while (!buf_mem_done);
		buf_mem_req <= '0;   // Dropped on the edge that sees done.
		@(negedge buf_mem_resp);   // Checker has sampled done by now.
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		mem_line_t test_lines [num_entries + 2];
		mem_word_t address;
		logic      is_write;
		rst         = 1'b1;
		buf_mem_req = '0;
		void'($urandom(24));
		apply_reset();

		checker_inst.begin_test(1'b1, 1'b0);
		run_op(1'b0, 16'h0140, '0);
		checker_inst.end_test("read miss returns memory pattern");

		checker_inst.begin_test(1'b1, 1'b1);
		run_op(1'b1, 16'h0200, random_line());
		run_op(1'b0, 16'h0200, '0);
		checker_inst.end_test("write then read hit");

		checker_inst.begin_test(1'b1, 1'b1);
		run_op(1'b1, 16'h0204, random_line());
		run_op(1'b0, 16'h021c, '0);
		checker_inst.end_test("rewrite of held line");

		apply_reset();
		checker_inst.begin_test(1'b1, 1'b0);
		for (int i = 0; i < num_entries + 2; i++)
		begin
			test_lines[i] = random_line();
			if (i < 2)
				checker_inst.expect_writeback({7'h02, 4'(i), 5'h00}, test_lines[i]);
			run_op(1'b1, {7'h02, 4'(i), 5'h00}, test_lines[i]);
		end
		for (int i = 0; i < num_entries + 2; i++)
			run_op(1'b0, {7'h02, 4'(i), 5'h00}, '0);
		checker_inst.end_test("FIFO writeback when full");

		checker_inst.begin_test(1'b0, 1'b0);
		repeat (200)
		begin
			address  = {7'h04, 4'($urandom_range(15)), 5'($urandom_range(31))};
			is_write = 1'($urandom_range(1));
			run_op(is_write, address, random_line());
		end
		checker_inst.end_test("random reads and writes");

		checker_inst.report_counts();
		if (checker_inst.error_count == 0 && victim_cache_inst.props_inst.failures == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	always @(posedge buf_mem_resp)
	begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles)
		begin
			$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
			$display("Simulation failed");
			$finish;
		end
	end

endmodule : victim_cache_tb

`default_nettype wire

// File: victim_cache/victim_cache.sv
`timescale 1ns/1ps
`default_nettype none

module victim_cache
	import mem_bus_pkg::*;
	import victim_pkg::*;
#(
	parameter int num_entries = 4,
	localparam int index_bits = $clog2(num_entries)
)
(
	input  logic      buf_mem_resp,
	input  logic      rst,
	input  mem_req_t  buf_mem_req,
	output logic      buf_mem_done,
	output mem_line_t buf_mem_rdata,
	output mem_req_t  s_mem_req,
	input  logic      s_mem_resp,
	input  mem_line_t s_mem_rdata
);

	logic                   hit;
	logic [index_bits-1:0]  hit_index;
	logic [index_bits-1:0]  ptr;
	logic                   full;
	logic                   advance;
	logic [num_entries-1:0] tag_we;
	logic [num_entries-1:0] line_we;
	logic [num_entries-1:0] valid;
	vc_tag_t                tag_entries [num_entries];
	mem_line_t              line_entries [num_entries];
	vc_tag_t                oldest_tag;
	mem_line_t              oldest_line;
	mem_line_t              hit_line;

	assign oldest_tag  = tag_entries[ptr];    // Writeback candidate.
	assign oldest_line = line_entries[ptr];

	victim_ctrl #(.num_entries(num_entries)) ctrl_inst
	(
		.buf_mem_resp (buf_mem_resp),
		.rst          (rst),
		.buf_mem_req  (buf_mem_req),
		.buf_mem_done (buf_mem_done),
		.buf_mem_rdata(buf_mem_rdata),
		.s_mem_req    (s_mem_req),
		.s_mem_resp   (s_mem_resp),
		.s_mem_rdata  (s_mem_rdata),
		.hit          (hit),
		.hit_index    (hit_index),
		.ptr          (ptr),
		.full         (full),
		.advance      (advance),
		.tag_we       (tag_we),
		.line_we      (line_we),
		.valid        (valid),
		.oldest_tag   (oldest_tag),
		.oldest_line  (oldest_line),
		.hit_line     (hit_line)
	);

	repl_counter #(.num_entries(num_entries)) repl_inst
	(
		.buf_mem_resp(buf_mem_resp),
		.rst         (rst),
		.advance     (advance),
		.ptr         (ptr),
		.full        (full)
	);

	victim_lookup #(.num_entries(num_entries)) lookup_inst
	(
		.address  (buf_mem_req.address),
		.tags     (tag_entries),
		.lines    (line_entries),
		.valid    (valid),
		.hit      (hit),
		.hit_index(hit_index),
		.hit_line (hit_line)
	);

	victim_store #(.num_entries(num_entries), .payload_t(vc_tag_t)) tag_store_inst
	(
		.buf_mem_resp(buf_mem_resp),
		.rst         (rst),
		.we          (tag_we),
		.wdata       (tag_of(buf_mem_req.address)),
		.entries     (tag_entries)
	);

	victim_store #(.num_entries(num_entries), .payload_t(mem_line_t)) line_store_inst
	(
		.buf_mem_resp(buf_mem_resp),
		.rst         (rst),
		.we          (line_we),
		.wdata       (buf_mem_req.wdata),
		.entries     (line_entries)
	);

endmodule : victim_cache

`default_nettype wire

// File: victim_cache/victim_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module victim_ctrl
	import mem_bus_pkg::*;
	import victim_pkg::*;
#(
	parameter int num_entries = 4,
	localparam int index_bits = $clog2(num_entries)
)
(
	input  logic                   buf_mem_resp,
	input  logic                   rst,
	input  mem_req_t               buf_mem_req,
	output logic                   buf_mem_done,
	output mem_line_t              buf_mem_rdata,
	output mem_req_t               s_mem_req,
	input  logic                   s_mem_resp,
	input  mem_line_t              s_mem_rdata,
	input  logic                   hit,
	input  logic [index_bits-1:0]  hit_index,
	input  logic [index_bits-1:0]  ptr,
	input  logic                   full,
	output logic                   advance,
	output logic [num_entries-1:0] tag_we,
	output logic [num_entries-1:0] line_we,
	output logic [num_entries-1:0] valid,
	input  vc_tag_t                oldest_tag,
	input  mem_line_t              oldest_line,
	input  mem_line_t              hit_line
);

	vc_state_t state;
	vc_state_t state_next;
	mem_line_t rdata_q;

	////////////////////////////////////////////////////////////
	// Next state and store write enables
	////////////////////////////////////////////////////////////

	always_comb
	begin
		state_next = state;
		tag_we     = '0;
		line_we    = '0;
		advance    = 1'b0;
		unique case (state)
			idle:
				if (buf_mem_req.write)
				begin
					if (hit)
					begin
						line_we[hit_index] = 1'b1;   // Overwrite held line.
						state_next         = done;
					end
					else if (!full)
					begin
						tag_we[ptr]  = 1'b1;   // Take next free entry.
						line_we[ptr] = 1'b1;
						advance      = 1'b1;
						state_next   = done;
					end
					else
						state_next = writeback;
				end
				else if (buf_mem_req.read)
					state_next = hit ? done : fetch;
			writeback:
				if (s_mem_resp)
				begin
					// Oldest entry is out, reuse it for the new line.
					tag_we[ptr]  = 1'b1;
					line_we[ptr] = 1'b1;
					advance      = 1'b1;
					state_next   = done;
				end
			fetch:
				if (s_mem_resp)
					state_next = done;
			done:
				state_next = idle;
		endcase
	end

	always_ff @(posedge buf_mem_resp)
	begin
		if (rst)
		begin
			state <= idle;
			valid <= '0;
		end
		else
		begin
			state <= state_next;
			valid <= valid | tag_we;   // Entries never invalidate.
		end
	end

	// Returned line for either hit or miss.
	always_ff @(posedge buf_mem_resp)
	begin
		if (state == idle && !buf_mem_req.write && buf_mem_req.read && hit)
			rdata_q <= hit_line;
		else if (state == fetch && s_mem_resp)
			rdata_q <= s_mem_rdata;
	end

	////////////////////////////////////////////////////////////
	// Memory side request and upstream response
	////////////////////////////////////////////////////////////

	always_comb
	begin
		s_mem_req = '0;
		if (state == writeback)
		begin
			s_mem_req.write   = 1'b1;
			s_mem_req.address = line_address(oldest_tag);
			s_mem_req.wdata   = oldest_line;
		end
		else if (state == fetch)
		begin
			s_mem_req.read    = 1'b1;
			s_mem_req.address = buf_mem_req.address;   // Held by requester.
		end
	end

	assign buf_mem_done  = (state == done);
	assign buf_mem_rdata = rdata_q;

endmodule : victim_ctrl

`default_nettype wire

// File: victim_cache/victim_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module victim_lookup
	import mem_bus_pkg::*;
	import victim_pkg::*;
#(
	parameter int num_entries = 4,
	localparam int index_bits = $clog2(num_entries)
)
(
	input  mem_word_t              address,
	input  vc_tag_t                tags [num_entries],
	input  mem_line_t              lines [num_entries],
	input  logic [num_entries-1:0] valid,
	output logic                   hit,
	output logic [index_bits-1:0]  hit_index,
	output mem_line_t              hit_line
);

	vc_tag_t                want_tag;
	logic [num_entries-1:0] match;

	assign want_tag = tag_of(address);

	always_comb
	begin
		for (int i = 0; i < num_entries; i++)
			match[i] = valid[i] && (tags[i] == want_tag);   // Parallel compare.
	end

	// Tags are unique, so the lowest match is the only one.
	always_comb
	begin
		hit_index = '0;
		for (int i = num_entries - 1; i >= 0; i--)
			if (match[i])
				hit_index = index_bits'(i);
	end

	assign hit      = |match;
	assign hit_line = lines[hit_index];   // Don't care on a miss.

endmodule : victim_lookup

`default_nettype wire

// File: victim_cache/victim_store.sv
`timescale 1ns/1ps
`default_nettype none

module victim_store
#(
	parameter int num_entries = 4,
	parameter type payload_t = logic
)
(
	input  logic                   buf_mem_resp,
	input  logic                   rst,
	input  logic [num_entries-1:0] we,
	input  payload_t               wdata,
	output payload_t               entries [num_entries]
);

	// One register per entry, shared write data.
	always_ff @(posedge buf_mem_resp)
	begin
		if (rst)
		begin
			for (int i = 0; i < num_entries; i++)
				entries[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < num_entries; i++)
				if (we[i])
					entries[i] <= wdata;
		end
	end

endmodule : victim_store

`default_nettype wire
